// ==== ex_pkg.sv ====
/*
  Shared definitions for the execute stage.
  Holds the data and register address widths, the multiplier step count
  and the operator encodings for the ALU and the multiplier.
  Modules and the testbench pull it in with a wildcard import.
*/

package ex_pkg;

  ////////////////////////////////////////
  // Widths and sizes
  ////////////////////////////////////////

  // Data word width
  localparam int unsigned XLEN      = 32;
  // Register file address width
  localparam int unsigned RF_ADDR_W = 5;
  // Shift amount width, low bits of operand b
  localparam int unsigned SHAMT_W   = $clog2(XLEN);

  // One shift-add step per multiplier bit
  localparam int unsigned MUL_CYCLES = 32;
  // Step counter width
  localparam int unsigned MUL_CNT_W  = $clog2(MUL_CYCLES);

  ////////////////////////////////////////
  // Word types
  ////////////////////////////////////////

  typedef logic [XLEN-1:0]      word_t;
  typedef logic [RF_ADDR_W-1:0] rf_addr_t;

  ////////////////////////////////////////
  // Operator encodings
  ////////////////////////////////////////

  // ALU operators, compares last so they group in the encoding
  typedef enum logic [3:0] {
    ALU_ADD  = 4'h0,
    ALU_SUB  = 4'h1,
    ALU_AND  = 4'h2,
    ALU_OR   = 4'h3,
    ALU_XOR  = 4'h4,
    ALU_SLL  = 4'h5,
    ALU_SRL  = 4'h6,
    ALU_SRA  = 4'h7,
    ALU_SLT  = 4'h8,
    ALU_SLTU = 4'h9,
    ALU_EQ   = 4'hA,
    ALU_NE   = 4'hB,
    ALU_LT   = 4'hC,
    ALU_GE   = 4'hD,
    ALU_LTU  = 4'hE,
    ALU_GEU  = 4'hF
  } alu_op_e;

  // Multiplier operators, low word or unsigned high word
  typedef enum logic {
    MUL_LO = 1'b0,
    MUL_HU = 1'b1
  } mul_op_e;

endpackage

// ==== ex_alu.sv ====
/*
  Single-cycle ALU of the execute stage.
  Computes add, subtract, logic, shifts and set-less-than results,
  plus the compare bit used for branch decisions.
  Purely combinational; the stage registers the result in EX/WB.
*/

`timescale 1ns/1ps

module ex_alu import ex_pkg::*; (
  input  alu_op_e operator_i,
  input  word_t   operand_a_i,
  input  word_t   operand_b_i,
  output word_t   result_o,
  output logic    cmp_result_o
);

  // Adder and subtractor outputs
  word_t add_res;
  word_t sub_res;

  // Shifter
  logic [SHAMT_W-1:0] shamt;
  word_t              sll_res;
  word_t              srl_res;
  word_t              sra_res;

  // Compare flags
  logic is_equal;
  logic lt_signed;
  logic lt_unsigned;

  ////////////////////////////////////////
  // Arithmetic and shifts
  ////////////////////////////////////////

  assign add_res = operand_a_i + operand_b_i;
  assign sub_res = operand_a_i - operand_b_i;

  // Only the low bits of operand b count as shift amount
  assign shamt   = operand_b_i[SHAMT_W-1:0];
  assign sll_res = operand_a_i << shamt;
  assign srl_res = operand_a_i >> shamt;
  // Arithmetic shift keeps the sign bit
  assign sra_res = word_t'($signed(operand_a_i) >>> shamt);

  ////////////////////////////////////////
  // Compares
  ////////////////////////////////////////

  assign is_equal    = (operand_a_i == operand_b_i);
  assign lt_signed   = ($signed(operand_a_i) < $signed(operand_b_i));
  assign lt_unsigned = (operand_a_i < operand_b_i);

  // Compare bit, also valid for SLT and SLTU
  always_comb begin
    cmp_result_o = 1'b0;
    case (operator_i)
      ALU_SLT,
      ALU_LT:   cmp_result_o = lt_signed;
      ALU_SLTU,
      ALU_LTU:  cmp_result_o = lt_unsigned;
      ALU_EQ:   cmp_result_o = is_equal;
      ALU_NE:   cmp_result_o = !is_equal;
      ALU_GE:   cmp_result_o = !lt_signed;
      ALU_GEU:  cmp_result_o = !lt_unsigned;
      default:  cmp_result_o = 1'b0;
    endcase
  end

  ////////////////////////////////////////
  // Result mux
  ////////////////////////////////////////

  always_comb begin
    result_o = add_res;
    case (operator_i)
      ALU_ADD: result_o = add_res;
      ALU_SUB: result_o = sub_res;
      ALU_AND: result_o = operand_a_i & operand_b_i;
      ALU_OR:  result_o = operand_a_i | operand_b_i;
      ALU_XOR: result_o = operand_a_i ^ operand_b_i;
      ALU_SLL: result_o = sll_res;
      ALU_SRL: result_o = srl_res;
      ALU_SRA: result_o = sra_res;
      // Compare operators return the bit zero-extended
      default: result_o = word_t'(cmp_result_o);
    endcase
  end

endmodule

// ==== ex_mult.sv ====
/*
  Iterative radix-2 shift-add multiplier.
  Starts when valid_i rises while idle, takes one step per multiplier bit,
  then raises valid_o and holds the result until ready_i is seen.
  Returns the low word or the unsigned high word of the product.
*/

`timescale 1ns/1ps

module ex_mult import ex_pkg::*; (
  input  logic    clk,
  input  logic    rst_n,

  input  mul_op_e operator_i,
  input  word_t   op_a_i,
  input  word_t   op_b_i,

  input  logic    valid_i,
  input  logic    ready_i,
  output word_t   result_o,
  output logic    valid_o,
  output logic    ready_o
);

  typedef enum logic [1:0] {
    MUL_IDLE,
    MUL_COMPUTE,
    MUL_DONE
  } mul_state_e;

  mul_state_e state_q, state_d;
  logic [MUL_CNT_W-1:0] cnt_q, cnt_d;

  // Upper half is the partial product, lower half the remaining multiplier bits
  logic [2*XLEN-1:0] acc_q;
  word_t             mcand_q;
  mul_op_e           op_q;

  logic            start;
  logic            cnt_last;
  logic [XLEN:0]   partial_sum;

  assign start    = (state_q == MUL_IDLE) && valid_i;
  assign cnt_last = (cnt_q == MUL_CNT_W'(MUL_CYCLES - 1));

  ////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    cnt_d   = cnt_q;
    case (state_q)
      MUL_IDLE: begin
        cnt_d = '0;
        if (valid_i) begin
          state_d = MUL_COMPUTE;
        end
      end
      MUL_COMPUTE: begin
        // Kill or halt drops the operation
        if (!valid_i) begin
          state_d = MUL_IDLE;
        end else if (cnt_last) begin
          state_d = MUL_DONE;
        end else begin
          cnt_d = cnt_q + 1'b1;
        end
      end
      MUL_DONE: begin
        // Result leaves when WB takes it
        if (!valid_i || ready_i) begin
          state_d = MUL_IDLE;
        end
      end
      default: state_d = MUL_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= MUL_IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

  ////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////

  // Add multiplicand when the current multiplier bit is set
  assign partial_sum = {1'b0, acc_q[2*XLEN-1:XLEN]} + (acc_q[0] ? {1'b0, mcand_q} : '0);

  always_ff @(posedge clk) begin
    if (start) begin
      acc_q   <= {{XLEN{1'b0}}, op_b_i};
      mcand_q <= op_a_i;
      op_q    <= operator_i;
    end else if (state_q == MUL_COMPUTE) begin
      // Carry lands in the top bit after the shift
      acc_q <= {partial_sum, acc_q[XLEN-1:1]};
    end
  end

  assign result_o = (op_q == MUL_HU) ? acc_q[2*XLEN-1:XLEN] : acc_q[XLEN-1:0];
  assign valid_o  = (state_q == MUL_DONE);
  assign ready_o  = ((state_q == MUL_IDLE) && !valid_i) || (valid_o && ready_i);

endmodule

// ==== ex_wb_pipe.sv ====
/*
  EX/WB pipeline register.
  Loads the instruction when EX is valid and WB is ready, inserts a bubble
  when WB is ready and EX has nothing, and holds under back-pressure.
*/

`timescale 1ns/1ps

module ex_wb_pipe import ex_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,

  // From EX
  input  logic     ex_valid_i,
  input  logic     wb_ready_i,
  input  logic     rf_we_i,
  input  rf_addr_t rf_waddr_i,
  input  word_t    rf_wdata_i,
  input  word_t    pc_i,
  input  logic     bch_taken_i,

  // To WB
  output logic     wb_valid_o,
  output logic     wb_rf_we_o,
  output rf_addr_t wb_rf_waddr_o,
  output word_t    wb_rf_wdata_o,
  output word_t    wb_pc_o,
  output logic     wb_bch_taken_o
);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_valid_o     <= 1'b0;
      wb_rf_we_o     <= 1'b0;
      wb_rf_waddr_o  <= '0;
      wb_rf_wdata_o  <= '0;
      wb_pc_o        <= '0;
      wb_bch_taken_o <= 1'b0;
    end else begin
      if (ex_valid_i && wb_ready_i) begin
        wb_valid_o     <= 1'b1;
        wb_rf_we_o     <= rf_we_i;
        wb_pc_o        <= pc_i;
        wb_bch_taken_o <= bch_taken_i;
        // Address and data only move for writing instructions
        if (rf_we_i) begin
          wb_rf_waddr_o <= rf_waddr_i;
          wb_rf_wdata_o <= rf_wdata_i;
        end
      end else if (wb_ready_i) begin
        // WB drained but EX has nothing, so insert a bubble
        wb_valid_o <= 1'b0;
      end
      // Otherwise WB is stalled and keeps its contents
    end
  end

endmodule

// ==== ex_stage.sv ====
/*
  Execute stage of the in-order pipeline.
  Takes one decoded instruction, runs it through the ALU or the
  iterative multiplier, drives the branch decision towards fetch
  and registers the result into EX/WB for the writeback side.
  Kill drops the instruction in EX, halt freezes it.
*/

`timescale 1ns/1ps

module ex_stage import ex_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,

  // Decode side
  input  logic     instr_valid_i,
  input  logic     alu_en_i,
  input  logic     mul_en_i,
  input  logic     branch_i,
  input  alu_op_e  alu_op_i,
  input  mul_op_e  mul_op_i,
  input  word_t    operand_a_i,
  input  word_t    operand_b_i,
  input  word_t    branch_target_i,
  input  word_t    pc_i,
  input  logic     rf_we_i,
  input  rf_addr_t rf_waddr_i,

  // Controller and writeback levels
  input  logic     kill_ex_i,
  input  logic     halt_ex_i,
  input  logic     wb_ready_i,

  output logic     ex_ready_o,

  // Towards fetch
  output logic     branch_decision_o,
  output word_t    branch_target_o,

  // EX/WB register contents
  output logic     wb_valid_o,
  output logic     wb_rf_we_o,
  output rf_addr_t wb_rf_waddr_o,
  output word_t    wb_rf_wdata_o,
  output word_t    wb_pc_o,
  output logic     wb_bch_taken_o
);

  // Gated valid, low on kill or halt
  logic  instr_valid;
  logic  mul_en_gated;

  // Unit levels
  logic  alu_ready;
  logic  mul_ready;
  logic  mul_valid;
  logic  ex_valid;

  // Unit results
  word_t alu_result;
  logic  alu_cmp_result;
  word_t mul_result;
  word_t rf_wdata;

  assign instr_valid  = instr_valid_i && !kill_ex_i && !halt_ex_i;
  // Kill and halt both send the multiplier back to idle
  assign mul_en_gated = mul_en_i && instr_valid;

  ////////////////////////////////////////
  // ALU
  ////////////////////////////////////////

  ex_alu i_ex_alu (
    .operator_i   (alu_op_i),
    .operand_a_i  (operand_a_i),
    .operand_b_i  (operand_b_i),
    .result_o     (alu_result),
    .cmp_result_o (alu_cmp_result)
  );

  // Single cycle, so only WB back-pressure stalls it
  assign alu_ready = wb_ready_i;

  // Branch compare goes straight to fetch
  assign branch_decision_o = alu_cmp_result && branch_i && alu_en_i;
  assign branch_target_o   = branch_target_i;

  ////////////////////////////////////////
  // Multiplier
  ////////////////////////////////////////

  ex_mult i_ex_mult (
    .clk        (clk),
    .rst_n      (rst_n),
    .operator_i (mul_op_i),
    .op_a_i     (operand_a_i),
    .op_b_i     (operand_b_i),
    .valid_i    (mul_en_gated),
    .ready_i    (wb_ready_i),
    .result_o   (mul_result),
    .valid_o    (mul_valid),
    .ready_o    (mul_ready)
  );

  ////////////////////////////////////////
  // Write port and stage levels
  ////////////////////////////////////////

  // Ungated select is fine, rf_we is ignored for invalid instructions
  assign rf_wdata = mul_en_i ? mul_result : alu_result;

  // Killed instruction leaves at once, otherwise wait for units and WB
  assign ex_ready_o = kill_ex_i || (alu_ready && mul_ready && !halt_ex_i);

  // ALU is valid at once, a multiply once its result is out
  assign ex_valid = (alu_en_i || (mul_en_i && mul_valid)) && instr_valid;

  ////////////////////////////////////////
  // EX/WB register
  ////////////////////////////////////////

  ex_wb_pipe i_ex_wb_pipe (
    .clk            (clk),
    .rst_n          (rst_n),
    .ex_valid_i     (ex_valid),
    .wb_ready_i     (wb_ready_i),
    .rf_we_i        (rf_we_i),
    .rf_waddr_i     (rf_waddr_i),
    .rf_wdata_i     (rf_wdata),
    .pc_i           (pc_i),
    .bch_taken_i    (branch_decision_o),
    .wb_valid_o     (wb_valid_o),
    .wb_rf_we_o     (wb_rf_we_o),
    .wb_rf_waddr_o  (wb_rf_waddr_o),
    .wb_rf_wdata_o  (wb_rf_wdata_o),
    .wb_pc_o        (wb_pc_o),
    .wb_bch_taken_o (wb_bch_taken_o)
  );

endmodule

// ==== tb_ex_stage.sv ====
/*
  Testbench for the execute stage.
  Reads instructions and expected results from ex_stage_patterns.txt,
  plays the decode and writeback sides around the DUT with random WB
  back-pressure and halts, and checks every retired item in order.
*/

`timescale 1ns/1ps

module tb_ex_stage import ex_pkg::*; ();

  localparam int          CLK_PERIOD   = 4;
  localparam int          RESET_CYCLES = 10;
  localparam int          IDLE_CYCLES  = 3;
  localparam logic [31:0] LFSR_SEED    = 32'h8279;
  localparam int          MAX_LINES    = 64;
  localparam word_t       PC_BASE      = 32'h0000_1000;

  logic clk, rst_n;
  logic instr_valid_i, alu_en_i, mul_en_i, branch_i, rf_we_i;
  logic kill_ex_i, halt_ex_i, wb_ready_i;
  alu_op_e alu_op_i;
  mul_op_e mul_op_i;
  word_t operand_a_i, operand_b_i, branch_target_i, pc_i;
  rf_addr_t rf_waddr_i;
  logic ex_ready_o, branch_decision_o, wb_valid_o, wb_rf_we_o, wb_bch_taken_o;
  word_t branch_target_o, wb_rf_wdata_o, wb_pc_o;
  rf_addr_t wb_rf_waddr_o;

  // One entry per pattern line
  logic [7:0] p_kind [MAX_LINES];
  logic [3:0] p_op [MAX_LINES];
  int         p_rd [MAX_LINES];
  logic       p_we [MAX_LINES];
  logic       p_kill [MAX_LINES];
  word_t      p_a [MAX_LINES];
  word_t      p_b [MAX_LINES];
  word_t      p_target [MAX_LINES];
  word_t      p_exp [MAX_LINES];

  int idx, n_lines, n_expected, n_accepted, n_retired, mul_run;
  int value_errs, protocol_errs, cycle_cnt, timeout_limit;
  logic [31:0] lfsr_q;
  logic file_ok;
  // Line numbers of issued items still to retire
  int exp_q [$];

  ex_stage i_ex_stage (
    .clk (clk), .rst_n (rst_n),
    .instr_valid_i (instr_valid_i), .alu_en_i (alu_en_i), .mul_en_i (mul_en_i),
    .branch_i (branch_i), .alu_op_i (alu_op_i), .mul_op_i (mul_op_i),
    .operand_a_i (operand_a_i), .operand_b_i (operand_b_i),
    .branch_target_i (branch_target_i), .pc_i (pc_i),
    .rf_we_i (rf_we_i), .rf_waddr_i (rf_waddr_i),
    .kill_ex_i (kill_ex_i), .halt_ex_i (halt_ex_i), .wb_ready_i (wb_ready_i),
    .ex_ready_o (ex_ready_o),
    .branch_decision_o (branch_decision_o), .branch_target_o (branch_target_o),
    .wb_valid_o (wb_valid_o), .wb_rf_we_o (wb_rf_we_o), .wb_rf_waddr_o (wb_rf_waddr_o),
    .wb_rf_wdata_o (wb_rf_wdata_o), .wb_pc_o (wb_pc_o), .wb_bch_taken_o (wb_bch_taken_o)
  );

  always #(CLK_PERIOD/2) clk = ~clk;

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  // Right-shift Galois LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    lfsr_step = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One LFSR step per bit drawn
  task automatic take_bits(input int n, output logic [7:0] bits);
    bits = '0;
    for (int i = 0; i < n; i++) begin
      bits[i] = lfsr_q[0];
      lfsr_q  = lfsr_step(lfsr_q);
    end
  endtask

  function automatic word_t pc_of(input int k);
    pc_of = PC_BASE + word_t'(4 * k);
  endfunction

  task automatic value_error(input string what, input word_t got, input word_t exp, input int k);
    value_errs++;
    $display("error %0t ns: line %0d %s is %08h, expected %08h", $time, k, what, got, exp);
  endtask

  task automatic protocol_error(input string what);
    protocol_errs++;
    $display("error %0t ns: %s", $time, what);
  endtask

  task automatic print_counts();
    $display("errors: %0d value, %0d protocol; %0d of %0d items retired",
             value_errs, protocol_errs, n_retired, n_expected);
  endtask

  ////////////////////////////////////////
  // Pattern file
  ////////////////////////////////////////

  task automatic read_patterns(output logic ok);
    int fd, r, rd, we, kill;
    logic [31:0] tok;
    logic [3:0] op;
    logic [8*160-1:0] rest;
    word_t a, b, tgt, exp;
    n_lines    = 0;
    n_expected = 0;
    fd = $fopen("ex_stage_patterns.txt", "r");
    ok = (fd != 0);
    while (ok && !$feof(fd) && n_lines < MAX_LINES) begin
      r = $fscanf(fd, "%s", tok);
      if (r == 1 && tok == "#") begin
        // Skip column notes up to the end of the line
        r = $fgets(rest, fd);
      end else if (r == 1) begin
        r = $fscanf(fd, "%h %d %d %h %h %h %d %h", op, rd, we, a, b, tgt, kill, exp);
        p_kind[n_lines] = tok[7:0];
        p_op[n_lines]   = op;
        p_rd[n_lines]   = rd;
        p_we[n_lines]   = (we != 0);
        p_a[n_lines]    = a;
        p_b[n_lines]    = b;
        p_target[n_lines] = tgt;
        p_kill[n_lines] = (kill != 0);
        p_exp[n_lines]  = exp;
        if (kill == 0) n_expected++;
        n_lines++;
      end
    end
    if (ok) $fclose(fd);
    // Worst case every line is a multiply stalled four times over
    timeout_limit = n_lines * (MUL_CYCLES + 2) * 4 + 100;
  endtask

  ////////////////////////////////////////
  // Decode and writeback models
  ////////////////////////////////////////

  task automatic drive_line(input int k);
    if (k < n_lines) begin
      instr_valid_i   <= 1'b1;
      alu_en_i        <= (p_kind[k] != "M");
      mul_en_i        <= (p_kind[k] == "M");
      branch_i        <= (p_kind[k] == "B");
      alu_op_i        <= (p_kind[k] == "M") ? ALU_ADD : alu_op_e'(p_op[k]);
      mul_op_i        <= mul_op_e'(p_op[k][0]);
      operand_a_i     <= p_a[k];
      operand_b_i     <= p_b[k];
      branch_target_i <= p_target[k];
      pc_i            <= pc_of(k);
      rf_we_i         <= p_we[k];
      rf_waddr_i      <= rf_addr_t'(p_rd[k]);
      // Kill lasts one cycle since the line leaves EX on that edge
      kill_ex_i       <= p_kill[k];
    end else begin
      instr_valid_i <= 1'b0;
      alu_en_i      <= 1'b0;
      mul_en_i      <= 1'b0;
      branch_i      <= 1'b0;
      rf_we_i       <= 1'b0;
      kill_ex_i     <= 1'b0;
    end
  endtask

  // WB must be empty until the first instruction goes through
  task automatic expect_wb_empty();
    if (n_accepted == 0 && (wb_valid_o !== 1'b0 || wb_rf_we_o !== 1'b0)) begin
      protocol_error("WB valid or write enable set before the first instruction");
    end
  endtask

  task automatic retire_item();
    int k;
    logic taken;
    if (wb_valid_o && wb_ready_i) begin
      if (exp_q.size() == 0) begin
        protocol_error("WB retired an item that was never issued");
      end else begin
        k = exp_q.pop_front();
        taken = (p_kind[k] == "B") ? p_exp[k][0] : 1'b0;
        n_retired++;
        if (wb_pc_o !== pc_of(k)) value_error("wb_pc_o", wb_pc_o, pc_of(k), k);
        if (wb_rf_we_o !== p_we[k]) value_error("wb_rf_we_o", wb_rf_we_o, p_we[k], k);
        // Address and data only follow writing instructions
        if (p_we[k] && wb_rf_waddr_o !== rf_addr_t'(p_rd[k])) begin
          value_error("wb_rf_waddr_o", wb_rf_waddr_o, p_rd[k], k);
        end
        if (p_we[k] && wb_rf_wdata_o !== p_exp[k]) begin
          value_error("wb_rf_wdata_o", wb_rf_wdata_o, p_exp[k], k);
        end
        if (wb_bch_taken_o !== taken) value_error("wb_bch_taken_o", wb_bch_taken_o, taken, k);
      end
    end
  endtask

  // Checks on the line sitting in EX and its acceptance
  task automatic inspect_ex();
    logic [7:0] kind;
    logic       exp_taken;
    kind = p_kind[idx];
    // Only branch lines may raise the decision towards fetch
    exp_taken = (kind == "B") ? p_exp[idx][0] : 1'b0;
    if (branch_decision_o !== exp_taken) begin
      value_error("branch_decision_o", branch_decision_o, exp_taken, idx);
    end
    if (kind == "B" && branch_target_o !== p_target[idx]) begin
      value_error("branch_target_o", branch_target_o, p_target[idx], idx);
    end
    if (p_kill[idx]) begin
      if (!ex_ready_o) protocol_error("killed instruction held in EX");
    end else if (halt_ex_i) begin
      if (ex_ready_o) protocol_error("ex_ready_o high while EX is halted");
      // Halt drops the multiply and it restarts afterwards
      mul_run = 0;
    end else if (kind == "M") begin
      if (ex_ready_o && mul_run < MUL_CYCLES + 1) begin
        protocol_error("multiply left EX early");
      end
      if (ex_ready_o && !wb_ready_i) begin
        protocol_error("multiply left EX while WB was stalled");
      end
      if (!ex_ready_o && wb_ready_i && mul_run >= MUL_CYCLES + 1) begin
        protocol_error("multiply held in EX after its result was ready");
      end
      mul_run++;
    end else if (ex_ready_o !== wb_ready_i) begin
      protocol_error("ex_ready_o does not follow wb_ready_i for an ALU instruction");
    end
    if (ex_ready_o) begin
      if (!p_kill[idx]) exp_q.push_back(idx);
      n_accepted++;
      idx++;
      mul_run = 0;
    end
  endtask

  ////////////////////////////////////////
  // Run
  ////////////////////////////////////////

  task automatic run_test();
    logic [7:0] rnd;
    for (int c = 0; c < RESET_CYCLES + IDLE_CYCLES; c++) begin
      @(posedge clk);
      // Registers take their reset values on the first edge
      if (c > 0) expect_wb_empty();
      if (c == RESET_CYCLES - 1) rst_n <= 1'b1;
    end
    drive_line(0);
    while (idx < n_lines || exp_q.size() > 0) begin
      @(posedge clk);
      retire_item();
      expect_wb_empty();
      if (idx < n_lines) inspect_ex();
      // WB ready three cycles in four and halt about one in 32
      take_bits(2, rnd);
      wb_ready_i <= (rnd[1:0] != 2'b00);
      take_bits(5, rnd);
      halt_ex_i <= (idx < n_lines) && (rnd[4:0] == 5'h1F);
      drive_line(idx);
    end
    wb_ready_i <= 1'b1;
    halt_ex_i  <= 1'b0;
    repeat (3) begin
      @(posedge clk);
      if (wb_valid_o !== 1'b0) protocol_error("WB still holds an item after the last retire");
    end
    if (n_retired != n_expected) begin
      protocol_error($sformatf("%0d items retired, expected %0d", n_retired, n_expected));
    end
  endtask

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (timeout_limit > 0 && cycle_cnt >= timeout_limit) begin
      $display("Run timed out after %0d cycles before all items retired", cycle_cnt);
      print_counts();
      $display("Test FAILED");
      $finish;
    end
  end

  initial begin
    clk             = 1'b0;
    rst_n           = 1'b0;
    instr_valid_i   = 1'b0;
    alu_en_i        = 1'b0;
    mul_en_i        = 1'b0;
    branch_i        = 1'b0;
    alu_op_i        = ALU_ADD;
    mul_op_i        = MUL_LO;
    operand_a_i     = '0;
    operand_b_i     = '0;
    branch_target_i = '0;
    pc_i            = '0;
    rf_we_i         = 1'b0;
    rf_waddr_i      = '0;
    kill_ex_i       = 1'b0;
    halt_ex_i       = 1'b0;
    wb_ready_i      = 1'b1;
    idx             = 0;
    n_accepted      = 0;
    n_retired       = 0;
    mul_run         = 0;
    value_errs      = 0;
    protocol_errs   = 0;
    cycle_cnt       = 0;
    timeout_limit   = 0;
    lfsr_q          = LFSR_SEED;
    read_patterns(file_ok);
    if (!file_ok) begin
      $display("Could not open the pattern file ex_stage_patterns.txt");
      $display("Test FAILED");
      $finish;
    end else begin
      run_test();
      print_counts();
      if (value_errs + protocol_errs == 0) begin
        $display("Test OK");
      end else begin
        $display("Test FAILED");
      end
      $finish;
    end
  end

endmodule

// ==== ex_stage_patterns.txt ====
# kind op rd we op_a op_b target kill expected
# kind A alu, B branch, M multiply; op, operands, target, expected in hex; rd, we, kill decimal
A 0 1 1 00000005 00000007 00000000 0 0000000C
A 1 2 1 00000003 00000005 00000000 0 FFFFFFFE
A 2 3 1 F0F0F0F0 0FF00FF0 00000000 0 00F000F0
A 3 4 1 F0F0F0F0 0FF00FF0 00000000 0 FFF0FFF0
A 4 5 1 F0F0F0F0 0FF00FF0 00000000 0 FF00FF00
M 0 6 1 00001234 00005678 00000000 0 06260060
A 5 7 1 00000001 0000001F 00000000 0 80000000
A 6 8 1 80000000 00000004 00000000 0 08000000
A 7 9 1 80000000 00000004 00000000 0 F8000000
A 5 10 1 00000003 00000024 00000000 0 00000030
A 8 11 1 FFFFFFFF 00000001 00000000 0 00000001
A 9 12 1 FFFFFFFF 00000001 00000000 0 00000000
B A 0 0 00000010 00000010 00002000 0 00000001
B B 0 0 00000010 00000010 00002040 0 00000000
M 1 13 1 FFFFFFFF FFFFFFFF 00000000 0 FFFFFFFE
M 0 14 1 FFFFFFFF FFFFFFFF 00000000 0 00000001
B C 0 0 FFFFFFF0 00000005 00003000 0 00000001
B E 0 0 FFFFFFF0 00000005 00003004 0 00000000
B D 0 0 00000005 FFFFFFF0 00003008 0 00000001
B F 0 0 00000005 FFFFFFF0 0000300C 0 00000000
A 0 15 1 11111111 22222222 00000000 1 33333333
A 0 16 1 7FFFFFFF 00000001 00000000 0 80000000
M 0 17 1 00010000 00010000 00000000 1 00000000
M 1 18 1 00010000 00010000 00000000 0 00000001
A 0 19 0 0000AAAA 00005555 00000000 0 0000FFFF
M 0 20 1 12345678 00000010 00000000 0 23456780
B A 0 0 00000001 00000002 00004000 1 00000000
B B 0 0 00000001 00000002 00004010 0 00000001

// ==== sources.f ====
ex_pkg.sv
ex_alu.sv
ex_mult.sv
ex_wb_pipe.sv
ex_stage.sv
tb_ex_stage.sv

// ==== Bender.yml ====
package:
  name: ex_stage

sources:
  - ex_pkg.sv
  - ex_alu.sv
  - ex_mult.sv
  - ex_wb_pipe.sv
  - ex_stage.sv
  - target: test
    files:
      - tb_ex_stage.sv
